/* source/ram_cfg.svh */
// sizes for the banked ram and they must stay consistent with each other (banks equal 2**bank bits)
`ifndef RAM_CFG_SVH
`define RAM_CFG_SVH

// number of physical banks
`define RAM_BANKS 8

// bank index width
// log2 of RAM_BANKS
`define RAM_BANK_BITS 3

// word index inside one bank
// 512 words per bank
`define RAM_WORD_BITS 9

// byte lane inside one wide word
`define RAM_LANE_BITS 2

// port a data width
`define RAM_WIDE_BITS 32

// port b data width
`define RAM_NARROW_BITS 8

`endif

/* source/ram_pkg.sv */
// shared address and data types for the banked ram and widths come from the cfg header
`include "ram_cfg.svh"

package ram_pkg;

	// one port a data word
	typedef logic [`RAM_WIDE_BITS-1:0] wide_word_t;

	// one port b data byte
	typedef logic [`RAM_NARROW_BITS-1:0] narrow_byte_t;

	// port a word address
	// bank sits in the high bits so the flat address is {bank, word}
	typedef struct packed {
		logic [`RAM_BANK_BITS-1:0] bank;
		logic [`RAM_WORD_BITS-1:0] word;
	} wide_addr_t;

	// port b byte address over the same storage
	// lane is the low field and picks a byte of the wide word
	typedef struct packed {
		logic [`RAM_BANK_BITS-1:0] bank;
		logic [`RAM_WORD_BITS-1:0] word;
		logic [`RAM_LANE_BITS-1:0] lane;
	} narrow_addr_t;

	// port a request
	// read happens every cycle and we adds a write
	typedef struct packed {
		wide_addr_t addr;
		wide_word_t wdata;
		logic we;
	} wide_req_t;

endpackage

/* source/bank_ram.sv */
// one 512 word bank with a write-first wide port and a read-only byte port and both reads take one cycle
`timescale 1ns/1ps
`include "ram_cfg.svh"

module bank_ram (
	input logic rclk,
	input logic reset,
	input logic we,
	input logic [`RAM_WORD_BITS-1:0] a_word,
	input ram_pkg::wide_word_t wdata,
	output ram_pkg::wide_word_t a_rdata,
	input logic [`RAM_WORD_BITS-1:0] b_word,
	input logic [`RAM_LANE_BITS-1:0] b_lane,
	output ram_pkg::narrow_byte_t b_rdata
);

	// storage array, left uninitialized
	ram_pkg::wide_word_t mem [0:(1<<`RAM_WORD_BITS)-1];

	// port b pipeline
	// full word read from the array plus the lane that goes with it
	ram_pkg::wide_word_t b_word_q;
	logic [`RAM_LANE_BITS-1:0] b_lane_q;

	// write port
	// writes are blocked while reset is high
	always_ff @(posedge rclk) begin
		if (!reset && we) begin
			mem[a_word] <= wdata;
		end
	end

	// port a registered read
	// on a write the new word goes straight to the output (write-first)
	always_ff @(posedge rclk) begin
		if (reset) begin
			a_rdata <= '0;
		end else if (we) begin
			a_rdata <= wdata;
		end else begin
			a_rdata <= mem[a_word];
		end
	end

	// port b registered read
	// sees the array before this edge's write, so a collision gives old data
	always_ff @(posedge rclk) begin
		if (reset) begin
			b_word_q <= '0;
			b_lane_q <= '0;
		end else begin
			b_word_q <= mem[b_word];
			b_lane_q <= b_lane;
		end
	end

	// byte pick after the register
	// lane 0 is bits 7:0 and lane 3 is bits 31:24
	always_comb begin
		b_rdata = b_word_q[b_lane_q*`RAM_NARROW_BITS +: `RAM_NARROW_BITS];
	end

endmodule

/* source/bank_array.sv */
// eight banks sharing both port addresses and only the addressed bank stores a port a write
`timescale 1ns/1ps
`include "ram_cfg.svh"

module bank_array (
	input logic rclk,
	input logic reset,
	input ram_pkg::wide_req_t a_req,
	input ram_pkg::narrow_addr_t b_addr,
	output ram_pkg::wide_word_t bank_wide_out [`RAM_BANKS],
	output ram_pkg::narrow_byte_t bank_narrow_out [`RAM_BANKS]
);

	// one-hot write enable, one bit per bank
	logic [`RAM_BANKS-1:0] bank_we;

	// bank select demux
	// bank field of the port a address steers the strobe
	always_comb begin
		bank_we = '0;
		bank_we[a_req.addr.bank] = a_req.we;
	end

	// every bank reads on both ports each cycle
	// the select after the array decides which result is kept
	genvar i;
	generate
		for (i = 0; i < `RAM_BANKS; i++) begin : g_bank
			bank_ram u_bank (
				.rclk(rclk),
				.reset(reset),
				.we(bank_we[i]),
				.a_word(a_req.addr.word),
				.wdata(a_req.wdata),
				.a_rdata(bank_wide_out[i]),
				.b_word(b_addr.word),
				.b_lane(b_addr.lane),
				.b_rdata(bank_narrow_out[i])
			);
		end
	endgenerate

endmodule

/* source/read_select.sv */
// registered 8:1 bank select and output registers for both ports and outputs are 0 while in reset
`timescale 1ns/1ps
`include "ram_cfg.svh"

module read_select (
	input logic rclk,
	input logic reset,
	input logic [`RAM_BANK_BITS-1:0] a_bank,
	input logic [`RAM_BANK_BITS-1:0] b_bank,
	input ram_pkg::wide_word_t bank_wide_out [`RAM_BANKS],
	input ram_pkg::narrow_byte_t bank_narrow_out [`RAM_BANKS],
	output ram_pkg::wide_word_t a_rdata,
	output ram_pkg::narrow_byte_t b_rdata
);

	// bank indices delayed by one cycle
	// they line up with the data coming out of the banks
	logic [`RAM_BANK_BITS-1:0] a_sel_q;
	logic [`RAM_BANK_BITS-1:0] b_sel_q;

	// mux results ahead of the output registers
	ram_pkg::wide_word_t a_mux;
	ram_pkg::narrow_byte_t b_mux;

	// select registers
	// captured on the same edge as the bank read
	always_ff @(posedge rclk) begin
		if (reset) begin
			a_sel_q <= '0;
			b_sel_q <= '0;
		end else begin
			a_sel_q <= a_bank;
			b_sel_q <= b_bank;
		end
	end

	// 8:1 muxes
	always_comb begin
		a_mux = bank_wide_out[a_sel_q];
		b_mux = bank_narrow_out[b_sel_q];
	end

	// output registers
	// second cycle of the read latency
	always_ff @(posedge rclk) begin
		if (reset) begin
			a_rdata <= '0;
			b_rdata <= '0;
		end else begin
			a_rdata <= a_mux;
			b_rdata <= b_mux;
		end
	end

endmodule

/* source/banked_ram.sv */
// 4k x 32 write/read port and 16k x 8 read port over one store with a fixed two-cycle read latency
`timescale 1ns/1ps
`include "ram_cfg.svh"

module banked_ram (
	input logic rclk,
	input logic reset,
	input ram_pkg::wide_req_t a_req,
	input ram_pkg::narrow_addr_t b_addr,
	output ram_pkg::wide_word_t a_rdata,
	output ram_pkg::narrow_byte_t b_rdata
);

	// per-bank read data
	// valid one cycle after the address
	ram_pkg::wide_word_t bank_wide_out [`RAM_BANKS];
	ram_pkg::narrow_byte_t bank_narrow_out [`RAM_BANKS];

	// storage and write decode
	bank_array u_bank_array (
		.rclk(rclk),
		.reset(reset),
		.a_req(a_req),
		.b_addr(b_addr),
		.bank_wide_out(bank_wide_out),
		.bank_narrow_out(bank_narrow_out)
	);

	// bank select and output stage
	// bank fields come straight from the request
	// and are delayed inside to match the bank data
	read_select u_read_select (
		.rclk(rclk),
		.reset(reset),
		.a_bank(a_req.addr.bank),
		.b_bank(b_addr.bank),
		.bank_wide_out(bank_wide_out),
		.bank_narrow_out(bank_narrow_out),
		.a_rdata(a_rdata),
		.b_rdata(b_rdata)
	);

endmodule

/* verif/banked_ram_tb.sv */
// testbench for banked_ram and it must run from the project root so verif/banked_ram_tests.txt is found
`timescale 1ns/1ps
`include "ram_cfg.svh"

module banked_ram_tb;

	// one entry of the test file with 26 hex digits
	// b_pad keeps the byte address on a hex digit boundary
	typedef struct packed {
		logic [3:0] op;
		ram_pkg::wide_addr_t a_addr;
		ram_pkg::wide_word_t wdata;
		logic [1:0] b_pad;
		ram_pkg::narrow_addr_t b_addr;
		ram_pkg::wide_word_t a_exp;
		ram_pkg::narrow_byte_t b_exp;
	} test_rec_t;

	// operations of the test file
	typedef enum logic [3:0] {
		write_wide = 4'd0,
		read_wide = 4'd1,
		read_narrow = 4'd2,
		random_fill = 4'd3
	} op_t;

	// one issued cycle waiting for its results
	typedef struct packed {
		logic chk_a;
		logic chk_b;
		ram_pkg::wide_word_t a_exp;
		ram_pkg::narrow_byte_t b_exp;
	} expect_t;

	localparam int max_lines = 64;
	localparam int fill_count = 64;
	localparam int period_ns = 20;
	localparam int reset_cycles = 8;

	logic rclk;
	logic reset;
	ram_pkg::wide_req_t a_req;
	ram_pkg::narrow_addr_t b_addr;
	ram_pkg::wide_word_t a_rdata;
	ram_pkg::narrow_byte_t b_rdata;

	// raw file image and then the operations in order
	test_rec_t test_mem [0:max_lines-1];
	test_rec_t ops [$];

	// results in flight with the oldest at the front
	expect_t pipe [$];

	// reference model keyed by the 12-bit word address
	ram_pkg::wide_word_t model_mem [int];

	// watchdog limit armed once the file is loaded
	longint unsigned limit_ns;
	logic limit_set = 1'b0;

	banked_ram UUT (
		.rclk(rclk),
		.reset(reset),
		.a_req(a_req),
		.b_addr(b_addr),
		.a_rdata(a_rdata),
		.b_rdata(b_rdata)
	);

	// 20 ns clock
	initial begin
		rclk = 1'b0;
		forever #(period_ns / 2) rclk = ~rclk;
	end

	// watchdog
	initial begin
		wait (limit_set === 1'b1);
		#(limit_ns);
		abort_with($sformatf("timeout: the test sequence did not finish within %0d ns", limit_ns));
	end

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic abort_with(input string reason);
		$display("%s", reason);
		stop_run();
	endtask

	task automatic check_wide(input string name, input ram_pkg::wide_word_t expected,
			input ram_pkg::wide_word_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_narrow(input string name, input ram_pkg::narrow_byte_t expected,
			input ram_pkg::narrow_byte_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	// port a result at issue time
	// a write returns its own word since port a reads the address it writes
	function automatic ram_pkg::wide_word_t predict_wide(input ram_pkg::wide_addr_t a,
			input logic we, input ram_pkg::wide_word_t wdata);
		if (we) begin
			return wdata;
		end
		if (model_mem.exists(int'(a))) begin
			return model_mem[int'(a)];
		end
		return 'x;
	endfunction

	// port b result at issue time
	// called before the same cycle's write lands so a collision gives the old byte
	function automatic ram_pkg::narrow_byte_t predict_narrow(input ram_pkg::narrow_addr_t b);
		ram_pkg::wide_addr_t w;
		ram_pkg::wide_word_t word;
		w.bank = b.bank;
		w.word = b.word;
		if (!model_mem.exists(int'(w))) begin
			return 'x;
		end
		word = model_mem[int'(w)];
		// lane k is bits 8k+7:8k
		case (b.lane)
			2'd0: return word[7:0];
			2'd1: return word[15:8];
			2'd2: return word[23:16];
			default: return word[31:24];
		endcase
	endfunction

	// results are compared at the falling edge two edges after the DUT took the request
	// until the pipe is full the outputs still show the reset value
	task automatic compare_oldest(input int depth);
		expect_t e;
		if (pipe.size() > depth) begin
			e = pipe.pop_front();
			if (e.chk_a) begin
				check_wide("a_rdata", e.a_exp, a_rdata);
			end
			if (e.chk_b) begin
				check_narrow("b_rdata", e.b_exp, b_rdata);
			end
		end else begin
			check_wide("a_rdata", '0, a_rdata);
			check_narrow("b_rdata", '0, b_rdata);
		end
	endtask

	// one request on both ports entered at a rising edge and held until the next one
	task automatic issue_cycle(input ram_pkg::wide_addr_t a_addr, input logic we,
			input ram_pkg::wide_word_t wdata, input ram_pkg::narrow_addr_t b,
			input expect_t e);
		a_req.addr <= a_addr;
		a_req.wdata <= wdata;
		a_req.we <= we;
		b_addr <= b;
		pipe.push_back(e);
		if (we) begin
			model_mem[int'(a_addr)] = wdata;
		end
		@(negedge rclk);
		compare_oldest(2);
		@(posedge rclk);
	endtask

	// idle cycles until every result has come out
	task automatic drain_pipe();
		while (pipe.size() > 0) begin
			a_req.we <= 1'b0;
			@(negedge rclk);
			compare_oldest(0);
			@(posedge rclk);
		end
	endtask

	task automatic run_file_line(input test_rec_t rec, input int index);
		expect_t e;
		logic we;
		we = (rec.op == write_wide);
		e.chk_a = !$isunknown(rec.a_exp);
		e.chk_b = !$isunknown(rec.b_exp);
		e.a_exp = rec.a_exp;
		e.b_exp = rec.b_exp;
		if (rec.op == read_wide && !e.chk_a) begin
			abort_with($sformatf("test entry %0d reads port A with no expected word", index));
		end
		if (rec.op == read_narrow && !e.chk_b) begin
			abort_with($sformatf("test entry %0d reads port B with no expected byte", index));
		end
		// the file's values must agree with the model before they are trusted
		if (e.chk_a && predict_wide(rec.a_addr, we, rec.wdata) !== rec.a_exp) begin
			abort_with($sformatf("test entry %0d port A value disagrees with the model", index));
		end
		if (e.chk_b && predict_narrow(rec.b_addr) !== rec.b_exp) begin
			abort_with($sformatf("test entry %0d port B value disagrees with the model", index));
		end
		issue_cycle(rec.a_addr, we, rec.wdata, rec.b_addr, e);
	endtask

	// 64 random writes and then the same addresses read back on both ports
	task automatic run_random_fill();
		ram_pkg::wide_addr_t addrs [fill_count];
		ram_pkg::narrow_addr_t b;
		ram_pkg::wide_word_t data;
		logic [31:0] rnd;
		expect_t e;
		for (int i = 0; i < fill_count; i++) begin
			rnd = $urandom();
			data = $urandom();
			addrs[i] = rnd[11:0];
			b = {addrs[i], rnd[13:12]};
			e.chk_a = 1'b1;
			e.a_exp = data;
			// port b only checked where the word already holds known data
			e.b_exp = predict_narrow(b);
			e.chk_b = !$isunknown(e.b_exp);
			issue_cycle(addrs[i], 1'b1, data, b, e);
		end
		for (int i = 0; i < fill_count; i++) begin
			rnd = $urandom();
			b = {addrs[i], rnd[1:0]};
			e.chk_a = 1'b1;
			e.a_exp = predict_wide(addrs[i], 1'b0, '0);
			e.chk_b = 1'b1;
			e.b_exp = predict_narrow(b);
			issue_cycle(addrs[i], 1'b0, '0, b, e);
		end
	endtask

	initial begin
		int unsigned seed_echo;
		int fill_lines;
		longint unsigned cycles;
		seed_echo = $urandom(32'hb9344f3d);
		reset = 1'b1;
		a_req = '0;
		b_addr = '0;
		$readmemh("verif/banked_ram_tests.txt", test_mem);
		fill_lines = 0;
		// entries past the end of the file stay unknown
		for (int i = 0; i < max_lines; i++) begin
			if ($isunknown(test_mem[i].op)) begin
				break;
			end
			if (test_mem[i].op > random_fill) begin
				abort_with($sformatf("test entry %0d has an unknown operation", i));
			end
			if (test_mem[i].op == random_fill) begin
				fill_lines++;
			end
			ops.push_back(test_mem[i]);
		end
		if (ops.size() == 0) begin
			abort_with("no operations found in verif/banked_ram_tests.txt");
		end
		// reset plus one cycle per entry and two per random access plus drain and margin
		cycles = reset_cycles + ops.size() + fill_lines * 2 * fill_count + 2 + 20;
		limit_ns = cycles * period_ns;
		limit_set = 1'b1;
		// outputs hold 0 while reset is high
		repeat (reset_cycles - 1) begin
			@(posedge rclk);
			@(negedge rclk);
			check_wide("a_rdata", '0, a_rdata);
			check_narrow("b_rdata", '0, b_rdata);
		end
		// release on the 8th edge and the first request goes out on the same edge
		@(posedge rclk);
		reset <= 1'b0;
		foreach (ops[i]) begin
			if (ops[i].op == random_fill) begin
				run_random_fill();
			end else begin
				run_file_line(ops[i], i);
			end
		end
		drain_pipe();
		$display("No errors");
		$finish;
	end

endmodule

/* verif/banked_ram_tests.txt */
// each entry is op a_addr wdata b_addr a_exp b_exp joined by underscores
// op 0 write_wide 1 read_wide 2 read_narrow 3 random_fill and x marks an unchecked result
// one word into each bank with mixed word fields
0_005_11223344_0000_11223344_xx
0_2a0_55667788_0000_55667788_xx
0_5ff_99aabbcc_0000_99aabbcc_xx
0_600_ddeeff00_0000_ddeeff00_xx
0_923_0badf00d_0000_0badf00d_xx
0_a7e_cafebabe_0000_cafebabe_xx
0_d00_13579bdf_0000_13579bdf_xx
0_eff_2468ace0_0000_2468ace0_xx
// port a read back in mixed bank order
1_923_00000000_0000_0badf00d_xx
1_005_00000000_0000_11223344_xx
1_eff_00000000_0000_2468ace0_xx
1_2a0_00000000_0000_55667788_xx
1_5ff_00000000_0000_99aabbcc_xx
1_d00_00000000_0000_13579bdf_xx
1_600_00000000_0000_ddeeff00_xx
1_a7e_00000000_0000_cafebabe_xx
// all four lanes of bank 4 word 123
2_000_00000000_248c_xxxxxxxx_0d
2_000_00000000_248d_xxxxxxxx_f0
2_000_00000000_248e_xxxxxxxx_ad
2_000_00000000_248f_xxxxxxxx_0b
// both ports switch bank every cycle
1_005_00000000_3bfe_11223344_68
1_eff_00000000_0017_2468ace0_11
1_2a0_00000000_3400_55667788_df
1_d00_00000000_0a81_13579bdf_77
1_5ff_00000000_29fb_99aabbcc_ca
1_a7e_00000000_17fc_cafebabe_cc
// same cycle write and reads, new word on port a and old byte on port b
0_600_a5a55a5a_1801_a5a55a5a_ff
1_600_00000000_1801_a5a55a5a_5a
0_923_7e57c0de_248f_7e57c0de_0b
2_000_00000000_248f_xxxxxxxx_7e
// random writes then reads on both ports
3_000_00000000_0000_xxxxxxxx_xx

/* build.f */
+incdir+source
source/ram_pkg.sv
source/bank_ram.sv
source/bank_array.sv
source/read_select.sv
source/banked_ram.sv
verif/banked_ram_tb.sv

/* Bender.yml */
package:
  name: banked_ram

sources:
  - include_dirs:
      - source
    files:
      - source/ram_pkg.sv
      - source/bank_ram.sv
      - source/bank_array.sv
      - source/read_select.sv
      - source/banked_ram.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/banked_ram_tb.sv
